// File: hw/dmem.sv
`timescale 1ns/10ps

module dmem (
   input  logic                     clk,
   input  logic                     reset_i,

   input  mem_stage_pkg::lsu2dbus_s lsu2dbus_i,
   output mem_stage_pkg::dbus2lsu_s dbus2lsu_o
);

   logic [mem_stage_pkg::XLEN-1:0]        mem [mem_stage_pkg::DMEM_WORDS];

   logic [mem_stage_pkg::DMEM_ADDR_W-1:0] word_idx;
   logic                                  sample;
   logic [3:0]                            byte_en;
   logic [mem_stage_pkg::XLEN-1:0]        w_lanes;
   logic                                  ack_q;
   logic [mem_stage_pkg::XLEN-1:0]        r_data_q;

   assign word_idx = lsu2dbus_i.addr[mem_stage_pkg::DMEM_ADDR_W+1:2];

   // No new request is taken in the ack cycle
   assign sample = (lsu2dbus_i.ld_req | lsu2dbus_i.st_req) & ~ack_q;

   // Replicate store data into every lane, enable only the addressed ones
   always_comb begin
      case (lsu2dbus_i.st_ops)
         mem_stage_pkg::ST_OPS_SB : begin
            byte_en = 4'b0001 << lsu2dbus_i.addr[1:0];
            w_lanes = {4{lsu2dbus_i.w_data[7:0]}};
         end
         mem_stage_pkg::ST_OPS_SH : begin
            byte_en = lsu2dbus_i.addr[1] ? 4'b1100 : 4'b0011;
            w_lanes = {2{lsu2dbus_i.w_data[15:0]}};
         end
         mem_stage_pkg::ST_OPS_SW : begin
            byte_en = 4'b1111;
            w_lanes = lsu2dbus_i.w_data;
         end
         default : begin
            byte_en = 4'b0000;
            w_lanes = '0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= sample;
      end
   end

   // Read word returned with the ack one cycle later
   always_ff @(posedge clk) begin
      if (sample) begin
         r_data_q <= mem[word_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < mem_stage_pkg::DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (sample && lsu2dbus_i.st_req) begin
         for (int b = 0; b < 4; b++) begin
            if (byte_en[b]) begin
               mem[word_idx][8*b +: 8] <= w_lanes[8*b +: 8];
            end
         end
      end
   end

   always_comb begin
      dbus2lsu_o.r_data = r_data_q;
      dbus2lsu_o.ack    = ack_q;
   end

endmodule : dmem

// File: hw/lsu.sv
`timescale 1ns/10ps

module lsu (
   input  logic                     clk,
   input  logic                     reset_i,

   // Execute handshake
   input  logic                     exe_valid_i,
   input  mem_stage_pkg::exe2lsu_s  exe_data_i,
   output logic                     exe_ready_o,

   // Data bus
   input  mem_stage_pkg::dbus2lsu_s dbus2lsu_i,
   output mem_stage_pkg::lsu2dbus_s lsu2dbus_o,

   output mem_stage_pkg::lsu2wrb_s  lsu2wrb_o,
   output mem_stage_pkg::trap_s     trap_o
);

   typedef enum logic [1:0] {
      IDLE,
      HOLD,
      WAIT_ACK
   } lsu_state_e;

   lsu_state_e                     state_q;
   lsu_state_e                     state_d;
   mem_stage_pkg::exe2lsu_s        instr_q;

   logic                           is_load;
   logic                           is_store;
   logic                           misaligned;
   logic                           mem_go;
   logic                           bus_active;
   logic                           trap_valid;
   logic                           finish;
   logic                           accept;
   logic [7:0]                     rdata_byte;
   logic [15:0]                    rdata_hword;
   logic [mem_stage_pkg::XLEN-1:0] load_data;

   assign is_load  = (instr_q.ld_ops != mem_stage_pkg::LD_OPS_NONE);
   assign is_store = (instr_q.st_ops != mem_stage_pkg::ST_OPS_NONE);

   // Halfwords need bit 0 clear, words need bits 1:0 clear
   always_comb begin
      misaligned = 1'b0;
      case (instr_q.ld_ops)
         mem_stage_pkg::LD_OPS_LH,
         mem_stage_pkg::LD_OPS_LHU : misaligned = instr_q.alu_result[0];
         mem_stage_pkg::LD_OPS_LW  : misaligned = |instr_q.alu_result[1:0];
         default                   : begin
         end
      endcase
      case (instr_q.st_ops)
         mem_stage_pkg::ST_OPS_SH : misaligned = instr_q.alu_result[0];
         mem_stage_pkg::ST_OPS_SW : misaligned = |instr_q.alu_result[1:0];
         default                  : begin
         end
      endcase
   end

   assign mem_go     = (is_load | is_store) & ~misaligned;
   assign bus_active = (state_q == HOLD) | (state_q == WAIT_ACK);
   assign trap_valid = (state_q == HOLD) & misaligned;

   // Item leaves this cycle, so a new one may be taken
   assign finish      = ((state_q == HOLD) & ~mem_go) | ((state_q == WAIT_ACK) & dbus2lsu_i.ack);
   assign exe_ready_o = (state_q == IDLE) | finish;
   assign accept      = exe_valid_i & exe_ready_o;

   always_comb begin
      state_d = state_q;
      if (accept) begin
         state_d = HOLD;
      end else if ((state_q == HOLD) && mem_go) begin
         state_d = WAIT_ACK;
      end else if (finish) begin
         state_d = IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         instr_q <= exe_data_i;
      end
   end

   // Lane pick from the read word, then sign or zero extension
   always_comb begin
      case (instr_q.alu_result[1:0])
         2'b00   : rdata_byte = dbus2lsu_i.r_data[7:0];
         2'b01   : rdata_byte = dbus2lsu_i.r_data[15:8];
         2'b10   : rdata_byte = dbus2lsu_i.r_data[23:16];
         default : rdata_byte = dbus2lsu_i.r_data[31:24];
      endcase
      rdata_hword = instr_q.alu_result[1] ? dbus2lsu_i.r_data[31:16] : dbus2lsu_i.r_data[15:0];
      case (instr_q.ld_ops)
         mem_stage_pkg::LD_OPS_LB  : load_data = {{24{rdata_byte[7]}}, rdata_byte};
         mem_stage_pkg::LD_OPS_LBU : load_data = {24'b0, rdata_byte};
         mem_stage_pkg::LD_OPS_LH  : load_data = {{16{rdata_hword[15]}}, rdata_hword};
         mem_stage_pkg::LD_OPS_LHU : load_data = {16'b0, rdata_hword};
         mem_stage_pkg::LD_OPS_LW  : load_data = dbus2lsu_i.r_data;
         default                   : load_data = '0;
      endcase
   end

   // Request stays up from HOLD until the ack arrives
   always_comb begin
      lsu2dbus_o.addr   = instr_q.alu_result;
      lsu2dbus_o.w_data = instr_q.rs2_data;
      lsu2dbus_o.st_ops = instr_q.st_ops;
      lsu2dbus_o.ld_req = bus_active & is_load & ~misaligned;
      lsu2dbus_o.st_req = bus_active & is_store & ~misaligned;
   end

   always_comb begin
      lsu2wrb_o.alu_result = instr_q.alu_result;
      lsu2wrb_o.pc_next    = instr_q.pc_next;
      lsu2wrb_o.r_data     = load_data;
      lsu2wrb_o.rd_addr    = instr_q.rd_addr;
      // Stores never write a register
      lsu2wrb_o.rd_wr_req  = instr_q.rd_wr_req & ~is_store;
      lsu2wrb_o.rd_wrb_sel = instr_q.rd_wrb_sel;
      lsu2wrb_o.valid      = finish & ~trap_valid;
   end

   always_comb begin
      trap_o.valid    = trap_valid;
      trap_o.is_store = is_store;
      trap_o.pc_next  = instr_q.pc_next;
      trap_o.addr     = instr_q.alu_result;
   end

endmodule : lsu

// File: hw/mem_stage_pkg.sv
package mem_stage_pkg;

   // Datapath and register file widths
   localparam int XLEN      = 32;
   localparam int RF_ADDR_W = 5;

   // Data memory is word addressed through addr[9:2]
   localparam int DMEM_WORDS  = 256;
   localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

   typedef enum logic [2:0] {
      LD_OPS_NONE = 3'd0,
      LD_OPS_LB   = 3'd1,
      LD_OPS_LBU  = 3'd2,
      LD_OPS_LH   = 3'd3,
      LD_OPS_LHU  = 3'd4,
      LD_OPS_LW   = 3'd5
   } ld_ops_e;

   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'd0,
      ST_OPS_SB   = 2'd1,
      ST_OPS_SH   = 2'd2,
      ST_OPS_SW   = 2'd3
   } st_ops_e;

   // Source of the destination register value
   typedef enum logic [1:0] {
      RD_WRB_ALU     = 2'd0,
      RD_WRB_PC_NEXT = 2'd1,
      RD_WRB_LOAD    = 2'd2
   } rd_wrb_sel_e;

   // Instruction handed over from execute
   typedef struct packed {
      logic [XLEN-1:0]      alu_result;
      logic [XLEN-1:0]      rs2_data;
      logic [XLEN-1:0]      pc_next;
      logic [RF_ADDR_W-1:0] rd_addr;
      logic                 rd_wr_req;
      rd_wrb_sel_e          rd_wrb_sel;
      ld_ops_e              ld_ops;
      st_ops_e              st_ops;
   } exe2lsu_s;

   typedef struct packed {
      logic [XLEN-1:0] addr;
      logic [XLEN-1:0] w_data;
      st_ops_e         st_ops;
      logic            ld_req;
      logic            st_req;
   } lsu2dbus_s;

   typedef struct packed {
      logic [XLEN-1:0] r_data;
      logic            ack;
   } dbus2lsu_s;

   typedef struct packed {
      logic [XLEN-1:0]      alu_result;
      logic [XLEN-1:0]      pc_next;
      logic [XLEN-1:0]      r_data;
      logic [RF_ADDR_W-1:0] rd_addr;
      logic                 rd_wr_req;
      rd_wrb_sel_e          rd_wrb_sel;
      logic                 valid;
   } lsu2wrb_s;

   // Register file write port
   typedef struct packed {
      logic                 en;
      logic [RF_ADDR_W-1:0] addr;
      logic [XLEN-1:0]      data;
   } rf_wr_s;

   // Misaligned access report
   typedef struct packed {
      logic            valid;
      logic            is_store;
      logic [XLEN-1:0] pc_next;
      logic [XLEN-1:0] addr;
   } trap_s;

endpackage : mem_stage_pkg

// File: hw/mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top (
   input  logic                    clk,
   input  logic                    reset_i,

   // From execute
   input  logic                    exe_valid_i,
   input  mem_stage_pkg::exe2lsu_s exe_data_i,
   output logic                    exe_ready_o,

   // Register file write port and misalignment report
   output mem_stage_pkg::rf_wr_s   rf_wr_o,
   output mem_stage_pkg::trap_s    trap_o
);

   mem_stage_pkg::lsu2dbus_s lsu2dbus;
   mem_stage_pkg::dbus2lsu_s dbus2lsu;
   mem_stage_pkg::lsu2wrb_s  lsu2wrb;

   lsu u_lsu (
      .clk         (clk),
      .reset_i     (reset_i),
      .exe_valid_i (exe_valid_i),
      .exe_data_i  (exe_data_i),
      .exe_ready_o (exe_ready_o),
      .dbus2lsu_i  (dbus2lsu),
      .lsu2dbus_o  (lsu2dbus),
      .lsu2wrb_o   (lsu2wrb),
      .trap_o      (trap_o)
   );

   // Data memory on the bus
   dmem u_dmem (
      .clk        (clk),
      .reset_i    (reset_i),
      .lsu2dbus_i (lsu2dbus),
      .dbus2lsu_o (dbus2lsu)
   );

   wrb_select u_wrb (
      .clk       (clk),
      .reset_i   (reset_i),
      .lsu2wrb_i (lsu2wrb),
      .rf_wr_o   (rf_wr_o)
   );

endmodule : mem_stage_top

// File: hw/wrb_select.sv
`timescale 1ns/10ps

module wrb_select (
   input  logic                    clk,
   input  logic                    reset_i,

   input  mem_stage_pkg::lsu2wrb_s lsu2wrb_i,
   output mem_stage_pkg::rf_wr_s   rf_wr_o
);

   logic [mem_stage_pkg::XLEN-1:0]      wr_data;
   logic                                wr_en;
   logic                                wr_en_q;
   logic [mem_stage_pkg::RF_ADDR_W-1:0] wr_addr_q;
   logic [mem_stage_pkg::XLEN-1:0]      wr_data_q;

   always_comb begin
      case (lsu2wrb_i.rd_wrb_sel)
         mem_stage_pkg::RD_WRB_PC_NEXT : wr_data = lsu2wrb_i.pc_next;
         mem_stage_pkg::RD_WRB_LOAD    : wr_data = lsu2wrb_i.r_data;
         default                       : wr_data = lsu2wrb_i.alu_result;
      endcase
   end

   // x0 is hardwired to zero
   assign wr_en = lsu2wrb_i.valid & lsu2wrb_i.rd_wr_req & (lsu2wrb_i.rd_addr != '0);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_en_q <= 1'b0;
      end else begin
         wr_en_q <= wr_en;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         wr_addr_q <= lsu2wrb_i.rd_addr;
         wr_data_q <= wr_data;
      end
   end

   always_comb begin
      rf_wr_o.en   = wr_en_q;
      rf_wr_o.addr = wr_addr_q;
      rf_wr_o.data = wr_data_q;
   end

endmodule : wrb_select

// File: list.f
hw/mem_stage_pkg.sv
hw/lsu.sv
hw/dmem.sv
hw/wrb_select.sv
hw/mem_stage_top.sv
sim/mem_stage_sva.sv
sim/tb_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the memory stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_mem_stage -f list.f -o tb_mem_stage
if [ $? -ne 0 ]; then
   echo "ERROR: Verilator build failed"
   exit 1
fi

./obj_dir/tb_mem_stage +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "ERROR: simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" "$log"; then
   echo "FAIL: see $log"
   exit 1
fi

echo "PASS"
exit 0

// File: sim/mem_stage_sva.sv
`timescale 1ns/10ps

module mem_stage_sva (
   input logic                     clk,
   input logic                     reset_i,
   input logic                     exe_ready_i,
   input mem_stage_pkg::ld_ops_e   ld_ops_i,
   input mem_stage_pkg::lsu2dbus_s lsu2dbus_i,
   input mem_stage_pkg::dbus2lsu_s dbus2lsu_i,
   input mem_stage_pkg::trap_s     trap_i
);

   int   fail_cnt = 0;
   logic req;
   logic half_op;
   logic word_op;
   logic bad_align;

   assign req = lsu2dbus_i.ld_req | lsu2dbus_i.st_req;

   // Alignment rule taken from the bus address and the op width
   assign half_op   = (ld_ops_i == mem_stage_pkg::LD_OPS_LH) ||
                      (ld_ops_i == mem_stage_pkg::LD_OPS_LHU) ||
                      (lsu2dbus_i.st_ops == mem_stage_pkg::ST_OPS_SH);
   assign word_op   = (ld_ops_i == mem_stage_pkg::LD_OPS_LW) ||
                      (lsu2dbus_i.st_ops == mem_stage_pkg::ST_OPS_SW);
   assign bad_align = (half_op & lsu2dbus_i.addr[0]) |
                      (word_op & (lsu2dbus_i.addr[1:0] != 2'b00));

   // Address, data and op held until the memory answers
   req_stable_a : assert property (@(posedge clk) disable iff (reset_i)
      req && !dbus2lsu_i.ack |=> req && $stable(lsu2dbus_i))
   else begin
      fail_cnt = fail_cnt + 1;
      $error("bus request dropped or changed before ack");
   end

   // Misaligned access is trapped and never reaches the bus
   trap_on_misalign_a : assert property (@(posedge clk) disable iff (reset_i)
      (req || trap_i.valid) |-> (trap_i.valid == bad_align))
   else begin
      fail_cnt = fail_cnt + 1;
      $error("trap and bus request disagree with the address alignment");
   end

   // Execute stalls in the request cycle and resumes with the ack
   stall_on_wait_a : assert property (@(posedge clk) disable iff (reset_i)
      req && !dbus2lsu_i.ack |-> !exe_ready_i ##1 (dbus2lsu_i.ack && exe_ready_i))
   else begin
      fail_cnt = fail_cnt + 1;
      $error("execute ready while waiting for ack or ack late");
   end

endmodule : mem_stage_sva

bind lsu mem_stage_sva u_sva (
   .clk         (clk),
   .reset_i     (reset_i),
   .exe_ready_i (exe_ready_o),
   .ld_ops_i    (instr_q.ld_ops),
   .lsu2dbus_i  (lsu2dbus_o),
   .dbus2lsu_i  (dbus2lsu_i),
   .trap_i      (trap_o)
);

// File: sim/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;

   // Instruction kinds used in the stimulus table
   typedef enum logic [3:0] {
      OP_ALU, OP_JAL, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW
   } op_e;

   typedef enum logic [1:0] {
      OUT_NONE,
      OUT_WRITE,
      OUT_TRAP
   } outcome_e;

   typedef struct packed {
      op_e         op;
      logic [31:0] alu;
      logic [31:0] rs2;
      logic [4:0]  rd;
      outcome_e    outcome;
   } test_s;

   // One observed register write or trap
   typedef struct packed {
      logic        is_trap;
      logic        is_store;
      logic [4:0]  rd;
      logic [31:0] data;
      logic [31:0] pc;
   } event_s;

   logic                    clk;
   logic                    reset_i;
   logic                    exe_valid_i;
   mem_stage_pkg::exe2lsu_s exe_data_i;
   logic                    exe_ready_o;
   mem_stage_pkg::rf_wr_s   rf_wr_o;
   mem_stage_pkg::trap_s    trap_o;

   test_s      tbl[$];
   event_s     evt_q[$];
   logic [7:0] shadow [1024];
   integer     seed;
   int         acc_cnt;
   int         pass_cnt;
   int         err_cnt;
   int         sva_cnt;

   mem_stage_top u_dut (
      .clk         (clk),
      .reset_i     (reset_i),
      .exe_valid_i (exe_valid_i),
      .exe_data_i  (exe_data_i),
      .exe_ready_o (exe_ready_o),
      .rf_wr_o     (rf_wr_o),
      .trap_o      (trap_o)
   );

   always #5 clk = ~clk;

   // Outputs settle after the rising edge and are sampled mid cycle
   always @(negedge clk) begin
      if (!reset_i) begin
         if (rf_wr_o.en) begin
            evt_q.push_back(event_s'{1'b0, 1'b0, rf_wr_o.addr, rf_wr_o.data, 32'h0});
         end
         if (trap_o.valid) begin
            evt_q.push_back(event_s'{1'b1, trap_o.is_store, 5'd0, trap_o.addr, trap_o.pc_next});
         end
      end
   end

   function automatic logic [31:0] pc_of(int idx);
      return 32'h0000_1000 + 32'(4 * idx);
   endfunction

   function automatic logic is_store_op(op_e op);
      return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
   endfunction

   task automatic add_entry(op_e op, logic [31:0] alu, logic [31:0] rs2, logic [4:0] rd,
                            outcome_e outcome);
      tbl.push_back(test_s'{op, alu, rs2, rd, outcome});
   endtask

   // Stores also ask for a register write that the stage must drop
   function automatic mem_stage_pkg::exe2lsu_s build_instr(test_s t, logic [31:0] pc);
      mem_stage_pkg::exe2lsu_s x;
      x.alu_result = t.alu;
      x.rs2_data   = t.rs2;
      x.pc_next    = pc;
      x.rd_addr    = t.rd;
      x.rd_wr_req  = 1'b1;
      x.rd_wrb_sel = mem_stage_pkg::RD_WRB_ALU;
      x.ld_ops     = mem_stage_pkg::LD_OPS_NONE;
      x.st_ops     = mem_stage_pkg::ST_OPS_NONE;
      case (t.op)
         OP_JAL  : x.rd_wrb_sel = mem_stage_pkg::RD_WRB_PC_NEXT;
         OP_LB   : x.ld_ops = mem_stage_pkg::LD_OPS_LB;
         OP_LBU  : x.ld_ops = mem_stage_pkg::LD_OPS_LBU;
         OP_LH   : x.ld_ops = mem_stage_pkg::LD_OPS_LH;
         OP_LHU  : x.ld_ops = mem_stage_pkg::LD_OPS_LHU;
         OP_LW   : x.ld_ops = mem_stage_pkg::LD_OPS_LW;
         OP_SB   : x.st_ops = mem_stage_pkg::ST_OPS_SB;
         OP_SH   : x.st_ops = mem_stage_pkg::ST_OPS_SH;
         OP_SW   : x.st_ops = mem_stage_pkg::ST_OPS_SW;
         default : x.rd_wrb_sel = mem_stage_pkg::RD_WRB_ALU;
      endcase
      if (x.ld_ops != mem_stage_pkg::LD_OPS_NONE) begin
         x.rd_wrb_sel = mem_stage_pkg::RD_WRB_LOAD;
      end
      return x;
   endfunction

   // Little endian byte model of the data memory
   function automatic logic [31:0] expect_value(test_s t, logic [31:0] pc);
      logic [9:0]  a;
      logic [7:0]  b;
      logic [15:0] h;
      a = t.alu[9:0];
      b = shadow[a];
      h = {shadow[a + 10'd1], shadow[a]};
      case (t.op)
         OP_JAL  : return pc;
         OP_LB   : return {{24{b[7]}}, b};
         OP_LBU  : return {24'h0, b};
         OP_LH   : return {{16{h[15]}}, h};
         OP_LHU  : return {16'h0, h};
         OP_LW   : return {shadow[a + 10'd3], shadow[a + 10'd2], h};
         default : return t.alu;
      endcase
   endfunction

   task automatic store_shadow(test_s t);
      logic [9:0] a;
      a = t.alu[9:0];
      shadow[a] = t.rs2[7:0];
      if (t.op != OP_SB) begin
         shadow[a + 10'd1] = t.rs2[15:8];
      end
      if (t.op == OP_SW) begin
         shadow[a + 10'd2] = t.rs2[23:16];
         shadow[a + 10'd3] = t.rs2[31:24];
      end
   endtask

   task automatic fill_table();
      add_entry(OP_ALU, 32'h1234_5678, 32'h0000_0000, 5'd1,  OUT_WRITE);
      add_entry(OP_JAL, 32'hdead_beef, 32'h0000_0000, 5'd2,  OUT_WRITE);
      add_entry(OP_ALU, 32'h5555_aaaa, 32'h0000_0000, 5'd0,  OUT_NONE);
      add_entry(OP_SW,  32'h0000_0040, 32'h8765_4321, 5'd3,  OUT_NONE);
      add_entry(OP_LW,  32'h0000_0040, 32'h0000_0000, 5'd4,  OUT_WRITE);
      add_entry(OP_SB,  32'h0000_0080, 32'h0000_01c3, 5'd3,  OUT_NONE);
      add_entry(OP_SB,  32'h0000_0081, 32'h0000_00f5, 5'd3,  OUT_NONE);
      add_entry(OP_SB,  32'h0000_0082, 32'h0000_0097, 5'd3,  OUT_NONE);
      add_entry(OP_LW,  32'h0000_0080, 32'h0000_0000, 5'd5,  OUT_WRITE);
      add_entry(OP_LB,  32'h0000_0081, 32'h0000_0000, 5'd6,  OUT_WRITE);
      add_entry(OP_LBU, 32'h0000_0082, 32'h0000_0000, 5'd7,  OUT_WRITE);
      add_entry(OP_LB,  32'h0000_0080, 32'h0000_0000, 5'd16, OUT_WRITE);
      add_entry(OP_SH,  32'h0000_00c2, 32'h0000_9abc, 5'd3,  OUT_NONE);
      add_entry(OP_SH,  32'h0000_00c0, 32'h1111_7001, 5'd3,  OUT_NONE);
      add_entry(OP_LH,  32'h0000_00c2, 32'h0000_0000, 5'd8,  OUT_WRITE);
      add_entry(OP_LHU, 32'h0000_00c2, 32'h0000_0000, 5'd9,  OUT_WRITE);
      add_entry(OP_LH,  32'h0000_00c0, 32'h0000_0000, 5'd10, OUT_WRITE);
      add_entry(OP_LH,  32'h0000_0043, 32'h0000_0000, 5'd14, OUT_TRAP);
      add_entry(OP_LW,  32'h0000_0042, 32'h0000_0000, 5'd15, OUT_TRAP);
      add_entry(OP_SH,  32'h0000_0041, 32'h0000_ffff, 5'd3,  OUT_TRAP);
      add_entry(OP_SW,  32'h0000_0046, 32'hffff_ffff, 5'd3,  OUT_TRAP);
      add_entry(OP_LW,  32'h0000_0044, 32'h0000_0000, 5'd11, OUT_WRITE);
      add_entry(OP_LW,  32'h0000_0040, 32'h0000_0000, 5'd12, OUT_WRITE);
      add_entry(OP_SB,  32'h0000_0043, 32'h0000_0080, 5'd3,  OUT_NONE);
      add_entry(OP_LB,  32'h0000_0043, 32'h0000_0000, 5'd13, OUT_WRITE);
      add_entry(OP_ALU, 32'h0bad_f00d, 32'h0000_0000, 5'd31, OUT_WRITE);
   endtask

   // Holds each item until the DUT takes it with random gaps of 0 to 2 cycles
   task automatic drive_items();
      int gap;
      for (int i = 0; i < tbl.size(); i++) begin
         gap = $unsigned($random(seed)) % 3;
         if (gap > 0) begin
            exe_valid_i = 1'b0;
            repeat (gap) @(negedge clk);
         end
         exe_valid_i = 1'b1;
         exe_data_i  = build_instr(tbl[i], pc_of(i));
         while (!exe_ready_o) begin
            @(negedge clk);
         end
         @(negedge clk);
         acc_cnt++;
      end
      exe_valid_i = 1'b0;
   endtask

   task automatic check_items();
      test_s       t;
      event_s      ev;
      logic [31:0] pc;
      logic [31:0] expv;
      for (int i = 0; i < tbl.size(); i++) begin
         t  = tbl[i];
         pc = pc_of(i);
         if (t.outcome == OUT_NONE) begin
            while (acc_cnt <= i) begin
               @(posedge clk);
            end
            // Wait out the cycle where a wrong write of this item would show
            @(posedge clk);
            if (t.op != OP_ALU && t.op != OP_JAL) begin
               @(posedge clk);
            end
            if (is_store_op(t.op)) begin
               store_shadow(t);
            end
            if (evt_q.size() != 0 && !evt_q[0].is_trap) begin
               ev = evt_q.pop_front();
               err_cnt++;
               $display("mismatch at %0t: test %0d expected no write, got x%0d = %h",
                        $time, i, ev.rd, ev.data);
            end else begin
               pass_cnt++;
               $display("test %0d: ok, no register write", i);
            end
         end else begin
            expv = expect_value(t, pc);
            while (evt_q.size() == 0) begin
               @(posedge clk);
            end
            ev = evt_q.pop_front();
            if (t.outcome == OUT_TRAP) begin
               if (!ev.is_trap || ev.is_store != is_store_op(t.op) || ev.data != t.alu ||
                   ev.pc != pc) begin
                  err_cnt++;
                  $display("mismatch at %0t: test %0d expected trap at %h store %0b, got %s %h",
                           $time, i, t.alu, is_store_op(t.op),
                           ev.is_trap ? "trap at" : "write of", ev.data);
               end else begin
                  pass_cnt++;
                  $display("test %0d: ok, trap at %h", i, t.alu);
               end
            end else if (ev.is_trap || ev.rd != t.rd || ev.data != expv) begin
               err_cnt++;
               $display("mismatch at %0t: test %0d expected x%0d = %h, got %s x%0d = %h",
                        $time, i, t.rd, expv, ev.is_trap ? "trap" : "write", ev.rd, ev.data);
            end else begin
               pass_cnt++;
               $display("test %0d: ok, x%0d = %h", i, t.rd, expv);
            end
         end
      end
   endtask

   initial begin
      clk         = 1'b0;
      reset_i     = 1'b1;
      exe_valid_i = 1'b0;
      exe_data_i  = '0;
      seed        = 13;
      acc_cnt     = 0;
      pass_cnt    = 0;
      err_cnt     = 0;
      shadow      = '{default: 8'h00};
      fill_table();

      // Watchdog allows ten cycles per table entry plus reset
      fork
         begin
            #((tbl.size() * 10 + 16) * 10);
            $display("timeout: the DUT did not finish all tests in time");
            $display("Testbench failed");
            $finish;
         end
      join_none

      repeat (16) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;

      fork
         drive_items();
         check_items();
      join

      // Quiet period for a late extra outcome
      repeat (3) @(posedge clk);
      if (evt_q.size() != 0) begin
         err_cnt++;
         $display("unexpected extra write or trap after the last test");
      end
      sva_cnt = u_dut.u_lsu.u_sva.fail_cnt;
      $display("%0d tests: %0d passed, %0d failed, %0d assertion failures",
               tbl.size(), pass_cnt, err_cnt, sva_cnt);
      if (err_cnt == 0 && sva_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule : tb_mem_stage
